//--- sim.f
hw/videoTimingPkg.sv
hw/videoBusPkg.sv
hw/pCycle.sv
hw/pBusLatch.sv
hw/fixPixelShift.sv
hw/pBusTop.sv
testbench/pBusTopTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= pBusTopTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
SIMBIN    := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Run and fail unless the pass line shows up
run: compile
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

//--- testbench/pBusTopTb.sv
`default_nettype none

module pBusTopTb;

	timeunit 1ns;
	timeprecision 100ps;

	import videoBusPkg::*;

	localparam int pixTicks    = 4;  // Fix pixel length given to the DUT
	localparam int numRows     = 8;
	localparam int numPeriods  = numRows + 1; // Extra line so the last fix palette is seen
	localparam int resetCycles = 10;
	localparam int lineTicks   = 32;
	localparam int cycleLimit  = resetCycles + (numRows + 2) * lineTicks;

	// One stimulus row and the values the rules predict for it
	typedef struct packed {
		cycleInT     stim;
		logic [7:0]  l0Rom;   // L0 ROM answer for this line
		pBusT        busSpr;  // Bus word in slot 1
		pBusT        busL0;   // Slot 4
		pBusT        busAttr; // Slot 14
		pBusT        busFix;  // Slot 17
		pBusT        busPal;  // Slot 30
		cRomAddrT    cRom;
		logic [15:0] sCap;    // Upper 16 bits of the S ROM address
		sprAttrT     attr;
	} rowT;

	logic     CLK_24M;
	logic     nRESET;
	cycleInT  cycleIn;
	logic [7:0] l0RomData;
	logic [7:0] fixRomData;
	pBusT     pBus;
	logic     pck1;
	logic     pck2;
	logic     load;
	logic     s1h1;
	logic     s2h1;
	logic     nVcs;
	logic [7:0] l0Data;
	cRomAddrT cRomAddr;
	sRomAddrT sRomAddr;
	sprAttrT  sprAttr;
	fixPixelT fixPix;

	rowT stimTable [numRows];
	rowT cur;  // Row driven in this line
	rowT prev; // Row of the line before and zero at first

	integer seed;
	int     errCount;
	int     testErrs;
	int     checkCount;
	int     cycleCnt = 0;

	// Model of the latched state
	cRomAddrT    cModel;
	logic [15:0] sCapModel;
	sprAttrT     attrModel;
	fixPalT      palModel;
	logic [7:0]  l0Model;

	// Pixel pair model
	logic       havePair;
	logic [7:0] pairByte;
	fixPalT     pairPal;
	int         pairTicks; // Slots since the pair was taken

	pBusTop #(
		.pixelTicks (pixTicks)
	) u_pBusTop (
		.CLK_24M    (CLK_24M),
		.nRESET     (nRESET),
		.cycleIn    (cycleIn),
		.l0RomData  (l0RomData),
		.fixRomData (fixRomData),
		.pBus       (pBus),
		.pck1       (pck1),
		.pck2       (pck2),
		.load       (load),
		.s1h1       (s1h1),
		.s2h1       (s2h1),
		.nVcs       (nVcs),
		.l0Data     (l0Data),
		.cRomAddr   (cRomAddr),
		.sRomAddr   (sRomAddr),
		.sprAttr    (sprAttr),
		.fixPix     (fixPix)
	);

	initial CLK_24M = 1'b0;
	always #10 CLK_24M = ~CLK_24M; // 20 ns period

	// Hard stop
	always @(posedge CLK_24M)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, the line sequence never completed", cycleCnt);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic compareValue(input string what, input int s,
		input logic [31:0] got, input logic [31:0] want);
		checkCount++;
		if (got !== want)
		begin
			$display("ERR %0t: slot %0d %s is %h, expected %h", $time, s, what, got, want);
			errCount++;
			testErrs++;
		end
	endtask

	// Expected words straight from the bus and latch rules
	function automatic rowT makeRow(input cycleInT stim, input logic [7:0] l0);
		rowT        r;
		sprRomAddrT sa;
		fixRomAddrT fa;
		sa = stim.sprRomAddr;
		fa = stim.fixRomAddr;
		r.stim    = stim;
		r.l0Rom   = l0;
		r.busSpr  = {sa[24:21], sa[3:0], sa[20:5]}; // Top nibble, low nibble, bits 20..5
		r.busL0   = {8'h00, stim.l0RomAddr};
		r.busAttr = {stim.sprPal, stim.sprXPos, 8'h00};
		r.busFix  = {8'h00, fa[4], fa[2:0], fa[16:5]};
		r.busPal  = {4'h0, stim.fixPal, 16'h0000};
		r.cRom    = {sa[24:5], sa[3:0]}; // CA4 dropped
		r.sCap    = {fa[16:4], fa[2:0]}; // Bit 3 gives way to S2H1 at the LSB
		r.attr    = {stim.sprPal, stim.sprXPos};
		return r;
	endfunction

	task automatic buildTable();
		logic [95:0] raw;
		cycleInT     stim;
		logic [7:0]  l0;
		for (int i = 0; i < numRows; i++)
		begin
			raw = {$random(seed), $random(seed), $random(seed)};
			if (i == 0)
			begin
				stim = '1; // Every bit set
				l0   = 8'hFF;
			end
			else if (i == 1)
			begin
				stim = {3{26'h2AAAAAA}}; // Alternating bits
				l0   = 8'h5A;
			end
			else
			begin
				stim = raw[77:0];
				l0   = raw[85:78];
			end
			stimTable[i] = makeRow(stim, l0);
		end
	endtask

	// Called once per slot on the falling edge
	task automatic verifySlot(input int p, input int s);
		logic [4:0] sl;
		sRomAddrT   expS;
		fixPixelT   expPix;
		sl = s[4:0];

		// Latched values that moved on the rising edge before this slot
		if (s == 1)
			palModel = prev.stim.fixPal; // Palette word left on the bus from the last line
		if (s == 2)
			cModel = cur.cRom;
		if (s == 13)
			l0Model = cur.l0Rom;
		if (s == 16)
			attrModel = cur.attr;
		if (s == 18)
			sCapModel = cur.sCap;
		if (havePair)
			pairTicks++;

		expS = {sCapModel, ~sl[4]};

		// Strobe decode
		compareValue("pck1", s, 32'(pck1), 32'(s == 0 || s == 1));
		compareValue("pck2", s, 32'(pck2), 32'(s == 16 || s == 17));
		compareValue("load", s, 32'(load), 32'(s == 15));
		compareValue("s1h1", s, 32'(s1h1), 32'(sl[3]));
		compareValue("s2h1", s, 32'(s2h1), 32'(!sl[4]));
		compareValue("nVcs", s, 32'(nVcs), 32'(!(s >= 3 && s <= 12)));

		// Bus words one slot after each load
		case (s)
			1:  compareValue("pBus sprite addr", s, 32'(pBus), 32'(cur.busSpr));
			4:  compareValue("pBus L0 addr", s, 32'(pBus), 32'(cur.busL0));
			14: compareValue("pBus sprite attr", s, 32'(pBus), 32'(cur.busAttr));
			17: compareValue("pBus fix addr", s, 32'(pBus), 32'(cur.busFix));
			20: compareValue("pBus blank", s, 32'(pBus), 32'h00FF0000);
			30: compareValue("pBus fix pal", s, 32'(pBus), 32'(cur.busPal));
			default: ;
		endcase

		compareValue("cRomAddr", s, 32'(cRomAddr), 32'(cModel));
		compareValue("sprAttr", s, 32'(sprAttr), 32'(attrModel));
		compareValue("sRomAddr", s, 32'(sRomAddr), 32'(expS));
		compareValue("l0Data", s, 32'(l0Data), 32'(l0Model));
		compareValue("fixPal", s, 32'(u_pBusTop.fixPal), 32'(palModel));

		// Low nibble first and then the high one for pixTicks slots each
		if (!havePair)
			expPix = '0;
		else
		begin
			expPix.pix = (pairTicks <= pixTicks) ? pairByte[3:0] : pairByte[7:4];
			expPix.pal = pairPal;
		end
		compareValue("fixPix", s, 32'(fixPix), 32'(expPix));

		// S1H1 toggles here except at the very first slot after reset
		if (sl[2:0] == 3'd0 && !(p == 0 && s == 0))
		begin
			pairByte  = expS[7:0]; // S ROM model answers with the address low byte
			pairPal   = palModel;
			pairTicks = 0;
			havePair  = 1'b1;
		end
	endtask

	initial
	begin
		int p;
		int s;
		seed       = 32'hb6f8;
		errCount   = 0;
		testErrs   = 0;
		checkCount = 0;
		nRESET     = 1'b0;
		cycleIn    = '0;
		l0RomData  = '0;
		fixRomData = '0;
		cur        = '0;
		prev       = '0;
		cModel     = '0;
		sCapModel  = '0;
		attrModel  = '0;
		palModel   = '0;
		l0Model    = '0;
		havePair   = 1'b0;
		pairByte   = '0;
		pairPal    = '0;
		pairTicks  = 0;

		buildTable();

		repeat (resetCycles) @(negedge CLK_24M);
		nRESET = 1'b1; // This slot is slot 0

		for (p = 0; p < numPeriods; p++)
		begin
			prev     = cur;
			cur      = stimTable[p % numRows];
			testErrs = 0;
			for (s = 0; s < lineTicks; s++)
			begin
				if (s == 0)
				begin
					cycleIn   = cur.stim;
					l0RomData = cur.l0Rom;
				end
				fixRomData = sRomAddr[7:0]; // S ROM model
				verifySlot(p, s);
				@(negedge CLK_24M);
			end
			$display("Line %0d (row %0d) done, %0d mismatches", p, p % numRows, testErrs);
		end

		$display("Checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/pBusTop.sv
`default_nettype none

module pBusTop #(
	parameter int pixelTicks = 4 // Fix pixel length in CLK_24M ticks
) (
	input  wire                       CLK_24M,
	input  wire                       nRESET,
	input  wire videoBusPkg::cycleInT cycleIn,
	input  wire [7:0]                 l0RomData,  // From the L0 ROM
	input  wire [7:0]                 fixRomData, // From the S ROM
	output videoBusPkg::pBusT         pBus,
	output wire                       pck1,
	output wire                       pck2,
	output wire                       load,
	output wire                       s1h1,
	output wire                       s2h1,
	output wire                       nVcs,
	output wire [7:0]                 l0Data,
	output videoBusPkg::cRomAddrT     cRomAddr,
	output videoBusPkg::sRomAddrT     sRomAddr,
	output videoBusPkg::sprAttrT      sprAttr,
	output videoBusPkg::fixPixelT     fixPix
);

	import videoBusPkg::*;

	fixPalT fixPal; // Latched fix palette into the pixel block

	// Sequencer
	pCycle u_pCycle (
		.CLK_24M   (CLK_24M),
		.nRESET    (nRESET),
		.cycleIn   (cycleIn),
		.l0RomData (l0RomData),
		.pBus      (pBus),
		.pck1      (pck1),
		.pck2      (pck2),
		.load      (load),
		.s1h1      (s1h1),
		.s2h1      (s2h1),
		.nVcs      (nVcs),
		.l0Data    (l0Data)
	);

	// External latches on the P bus
	pBusLatch u_pBusLatch (
		.CLK_24M  (CLK_24M),
		.nRESET   (nRESET),
		.pBus     (pBus),
		.pck1     (pck1),
		.pck2     (pck2),
		.load     (load),
		.s2h1     (s2h1),
		.cRomAddr (cRomAddr),
		.sRomAddr (sRomAddr),
		.sprAttr  (sprAttr),
		.fixPal   (fixPal)
	);

	// Fix pixel output, B1 stand-in
	fixPixelShift #(
		.pixelTicks (pixelTicks)
	) u_fixPixelShift (
		.CLK_24M    (CLK_24M),
		.nRESET     (nRESET),
		.s1h1       (s1h1),
		.fixRomData (fixRomData),
		.fixPal     (fixPal),
		.fixPixel   (fixPix)
	);

endmodule

`default_nettype wire

//--- hw/fixPixelShift.sv
`default_nettype none

module fixPixelShift #(
	parameter int pixelTicks = 4 // CLK_24M ticks per pixel
) (
	input  wire                     CLK_24M,
	input  wire                     nRESET,
	input  wire                     s1h1,       // Pair clock from the sequencer
	input  wire [7:0]               fixRomData, // Two pixels, low nibble first
	input  wire videoBusPkg::fixPalT fixPal,
	output videoBusPkg::fixPixelT   fixPixel
);

	import videoBusPkg::*;

	localparam int cntW = (pixelTicks > 1) ? $clog2(pixelTicks) : 1;
	localparam logic [cntW-1:0] lastTick = cntW'(pixelTicks - 1);

	logic s1h1Dly;  // For transition detect
	logic latchEn;  // Either edge of S1H1

	logic [7:0] pixPair; // Latched ROM byte
	fixPalT     pairPal; // Palette latched with it

	logic [cntW-1:0] tickCnt; // Ticks spent on the current nibble
	logic            hiSel;   // High nibble showing

	pixelT pixNow;

	assign latchEn = s1h1 ^ s1h1Dly;

	// Nibble select
	assign pixNow = hiSel ? pixPair[7:4] : pixPair[3:0];

	assign fixPixel = '{pix: pixNow, pal: pairPal};

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			s1h1Dly <= 1'b0;
			pixPair <= '0; // Output stays 0 until the first pair
			pairPal <= '0;
			tickCnt <= '0;
			hiSel   <= 1'b0;
		end
		else
		begin
			s1h1Dly <= s1h1;

			if (latchEn)
			begin
				// New pair, restart on the low nibble
				pixPair <= fixRomData;
				pairPal <= fixPal;
				tickCnt <= '0;
				hiSel   <= 1'b0;
			end
			else if (tickCnt == lastTick)
			begin
				tickCnt <= '0;
				hiSel   <= ~hiSel; // Alternates if pixels are short
			end
			else
			begin
				tickCnt <= tickCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/pBusLatch.sv
`default_nettype none

module pBusLatch (
	input  wire                    CLK_24M,
	input  wire                    nRESET,
	input  wire videoBusPkg::pBusT pBus,
	input  wire                    pck1,
	input  wire                    pck2,
	input  wire                    load,
	input  wire                    s2h1,     // Live fix address LSB
	output videoBusPkg::cRomAddrT  cRomAddr, // To the C ROMs
	output videoBusPkg::sRomAddrT  sRomAddr, // To the S ROM
	output videoBusPkg::sprAttrT   sprAttr,
	output videoBusPkg::fixPalT    fixPal    // To the fix pixel block
);

	// Strobe history for edge detection
	logic pck1Dly;
	logic pck2Dly;

	logic pck1Rise; // First PCK1 tick
	logic pck1Last; // Last PCK1 tick, edge after it ends the pulse
	logic pck2Last; // Same for PCK2

	logic [15:0] sRomCap; // Fix address bits from the bus, ROM order

	assign pck1Rise = pck1 & ~pck1Dly;
	assign pck1Last = pck1 & pck1Dly; // Pulses are two ticks wide
	assign pck2Last = pck2 & pck2Dly;

	// S2H1 picks the byte of the pair and is not latched
	assign sRomAddr = {sRomCap, s2h1};

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			pck1Dly <= 1'b0;
			pck2Dly <= 1'b0;
		end
		else
		begin
			pck1Dly <= pck1;
			pck2Dly <= pck2;
		end
	end

	// The 273 latches
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			cRomAddr <= '0;
			sRomCap  <= '0;
			sprAttr  <= '0;
			fixPal   <= '0;
		end
		else
		begin
			// Sprite address word, bus order is
			// top nibble, low nibble, bits 20..5
			if (pck1Last)
				cRomAddr <= {pBus[23:20], pBus[15:0], pBus[19:16]};

			// Fix palette word is still on the bus when PCK1 rises
			if (pck1Rise)
				fixPal <= pBus[19:16];

			// Fix address word, bus order is
			// bit 4, bits 2..0, bits 16..5
			if (pck2Last)
				sRomCap <= {pBus[11:0], pBus[15], pBus[14:12]};

			// Palette in the upper byte, X in the middle one
			if (load)
			begin
				sprAttr.sprPal <= pBus[23:16];
				sprAttr.xPos   <= pBus[15:8];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/pCycle.sv
`default_nettype none

module pCycle (
	input  wire                  CLK_24M,
	input  wire                  nRESET,
	input  wire videoBusPkg::cycleInT cycleIn,
	input  wire [7:0]            l0RomData,  // L0 ROM read back, separate from the bus
	output videoBusPkg::pBusT    pBus,
	output logic                 pck1,       // Sprite address latch strobe
	output logic                 pck2,       // Fix address latch strobe
	output logic                 load,       // Sprite attribute strobe
	output logic                 s1h1,       // Fix pixel pair clock
	output logic                 s2h1,       // Fix address LSB
	output logic                 nVcs,       // L0 ROM chip select
	output logic [7:0]           l0Data
);

	import videoTimingPkg::*;
	import videoBusPkg::*;

	localparam pBusT blankWord = 24'hFF0000; // Filler in slots 20..29

	slotT slot; // Position inside the line period

	// Bus words before registering
	pBusT sprWord;
	pBusT l0Word;
	pBusT attrWord;
	pBusT fixWord;
	pBusT palWord;

	// Sprite address in bus order
	// Top nibble, then the low nibble, then bits 20..5, CA4 left out
	assign sprWord = {cycleIn.sprRomAddr[24:21],
		cycleIn.sprRomAddr[3:0],
		cycleIn.sprRomAddr[20:5]};

	assign l0Word = {8'h00, cycleIn.l0RomAddr}; // Upper byte not driven on real hw

	assign attrWord = {cycleIn.sprPal, cycleIn.sprXPos, 8'h00};

	// Fix address in bus order
	// Bit 3 is replaced by S2H1 in the latch, so it never goes out
	assign fixWord = {8'h00,
		cycleIn.fixRomAddr[4],
		cycleIn.fixRomAddr[2:0],
		cycleIn.fixRomAddr[16:5]};

	assign palWord = {4'h0, cycleIn.fixPal, 16'h0000};

	// Free running slot counter
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			slot <= '0;
		end
		else
		begin
			slot <= slot + 5'd1; // Wraps at 32
		end
	end

	// Strobes decode straight from the slot
	assign pck1 = (slot[4:1] == slotSprAddr[4:1]); // Slots 0 and 1
	assign pck2 = (slot[4:1] == slotFixAddr[4:1]); // Slots 16 and 17
	assign load = (slot == slotLoad);
	assign s1h1 = slot[3];  // Toggles every 8 ticks
	assign s2h1 = ~slot[4]; // High in the first half line

	// nVCS window and L0 data capture
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			nVcs   <= 1'b1;
			l0Data <= '0;
		end
		else
		begin
			if (slot == slotVcsOn)
				nVcs <= 1'b0; // Low from slot 3
			else if (slot == slotVcsOff)
				nVcs <= 1'b1; // High again from slot 13

			// ROM has had the whole window to answer
			if (slot == slotVcsOff)
				l0Data <= l0RomData;
		end
	end

	// P bus multiplexer
	// Each word is registered at its load slot and held until the next one
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			pBus <= '0;
		end
		else
		begin
			case (slot)
				slotSprAddr: pBus <= sprWord;   // Seen by PCK1
				slotL0Addr:  pBus <= l0Word;    // Seen during nVCS
				slotSprAttr: pBus <= attrWord;  // Seen by LOAD
				slotFixAddr: pBus <= fixWord;   // Seen by PCK2
				slotBlank:   pBus <= blankWord;
				slotFixPal:  pBus <= palWord;   // Still there at slot 0
				default:     pBus <= pBus;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/videoBusPkg.sv
`default_nettype none

package videoBusPkg;

	// One word on the multiplexed P bus
	typedef logic [23:0] pBusT;

	// ROM addresses as the video logic computes them
	typedef logic [16:0] fixRomAddrT; // S ROM, bit 3 comes from S2H1 later
	typedef logic [24:0] sprRomAddrT; // C ROM, full byte address
	typedef logic [15:0] l0AddrT;     // L0 shrink table

	// Addresses rebuilt by the external latches
	typedef logic [23:0] cRomAddrT; // Sprite address with CA4 dropped
	typedef logic [16:0] sRomAddrT; // Fix address, LSB is live S2H1

	// Palettes and position
	typedef logic [3:0] fixPalT;
	typedef logic [7:0] sprPalT;
	typedef logic [7:0] xPosT;

	// One 4 bit pixel, two per fix ROM byte
	typedef logic [3:0] pixelT;

	// Everything the sequencer puts on the bus during one line
	typedef struct packed {
		fixRomAddrT fixRomAddr; // Loaded at slot 16
		fixPalT     fixPal;     // Loaded at slot 29
		sprRomAddrT sprRomAddr; // Loaded at slot 0
		sprPalT     sprPal;     // Upper byte of the slot 13 word
		xPosT       sprXPos;    // Middle byte of the slot 13 word
		l0AddrT     l0RomAddr;  // Loaded at slot 3
	} cycleInT;

	// Sprite attributes captured on LOAD
	typedef struct packed {
		sprPalT sprPal;
		xPosT   xPos;
	} sprAttrT;

	// Fix pixel out of the shifter
	// Palette travels with each pixel to the palette RAM lookup
	typedef struct packed {
		pixelT  pix;
		fixPalT pal;
	} fixPixelT;

endpackage

`default_nettype wire

//--- hw/videoTimingPkg.sv
`default_nettype none

package videoTimingPkg;

	// Tick number inside one line period
	// 32 ticks of CLK_24M, counter wraps on its own
	typedef logic [4:0] slotT;

	// Load slots for the P bus
	// A word loaded here shows on the bus from the next slot on

	localparam slotT slotSprAddr = 5'd0; // Sprite ROM address, PCK1 follows in 0..1

	localparam slotT slotL0Addr  = 5'd3; // L0 ROM address, upper byte zero

	localparam slotT slotSprAttr = 5'd13; // Sprite palette and X position

	localparam slotT slotFixAddr = 5'd16; // Fix ROM address, PCK2 follows in 16..17

	localparam slotT slotBlank   = 5'd19; // FF0000 filler word, held through slot 29

	localparam slotT slotFixPal  = 5'd29; // Fix palette, still on the bus at slot 0

	// Strobe and window slots

	localparam slotT slotLoad    = 5'd15; // LOAD high for this one tick

	// nVCS window for the L0 ROM
	// Registered, so the level changes one tick after the slot
	localparam slotT slotVcsOn   = 5'd2; // nVCS goes low after this slot

	localparam slotT slotVcsOff  = 5'd12; // nVCS back high, L0 data sampled here

	// Fix pixel pairs come every 8 ticks
	// S1H1 is slot bit 3 and S2H1 the inverse of slot bit 4
	// so a full 16 bit fix word spans one half line

endpackage

`default_nettype wire
